//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - files:
      - verilog/mem_arb_pkg.sv
      - verilog/scratch_burst.sv
      - verilog/memory_arbiter.sv
      - verilog/ram_model.sv
      - verilog/mem_subsystem_top.sv
  - target: test
    files:
      - sim/mem_arb_chk.sv
      - sim/tb_mem_subsystem.sv

//--- sim/mem_arb_chk.sv
module mem_arb_chk import mem_arb_pkg::*; (
  input logic CLK,
  input logic nRST,
  input logic sp_req,
  input logic sp_ack,
  input logic d_req,
  input logic d_ack,
  input logic i_req,
  input logic i_ack,
  input logic ram_strb,
  input logic ram_done
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // ack must stay up while the owner still holds req
  property ack_held(req, ack);
    @(posedge CLK) disable iff (!nRST) (ack && req) |=> ack;
  endproperty

  one_owner: assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({sp_ack, d_ack, i_ack}))
    else begin
      fail_count++;
      $error("more than one client ack is high");
    end

  strb_to_done: assert property (@(posedge CLK) disable iff (!nRST)
    ram_strb |-> ##RAM_LATENCY ram_done)
    else begin
      fail_count++;
      $error("ram_done missing RAM_LATENCY cycles after ram_strb");
    end

  done_from_strb: assert property (@(posedge CLK) disable iff (!nRST)
    ram_done |-> $past(ram_strb, RAM_LATENCY))
    else begin
      fail_count++;
      $error("ram_done without a ram_strb RAM_LATENCY cycles before");
    end

  sp_held: assert property (ack_held(sp_req, sp_ack))
    else begin
      fail_count++;
      $error("sp_ack fell while sp_req was high");
    end

  d_held: assert property (ack_held(d_req, d_ack))
    else begin
      fail_count++;
      $error("d_ack fell while d_req was high");
    end

  i_held: assert property (ack_held(i_req, i_ack))
    else begin
      fail_count++;
      $error("i_ack fell while i_req was high");
    end

endmodule

bind memory_arbiter mem_arb_chk mem_arb_chk_i (.*);

//--- sim/tb_mem_subsystem.sv
module tb_mem_subsystem import mem_arb_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int REGION_WORDS = 64;
  localparam int N_OPS        = 20;
  // fill and readback, data and fetch ops, scratchpad ops at up to eight words
  localparam int CYCLE_LIMIT = 40 * (2 * REGION_WORDS + 2 * N_OPS + 8 * N_OPS);

  logic       CLK = 1'b0;
  logic       nRST;
  logic       i_req, i_ack, d_req, d_ack;
  logic       sl_req, sl_ack, sl_row_valid, ss_req, ss_ack;
  addr_t      i_addr, sl_addr, ss_addr;
  word_t      i_rdata, d_rdata;
  mem_req_t   d_cmd;
  sp_row_t    sl_row;
  dword_t     ss_data;
  word_t      model [REGION_WORDS];
  integer     seed = 23;
  int         cycles = 0;
  int         since_reset = 0;
  logic [3:0] ack_q = '0;
  logic [3:0] req_q = '0;
  int         chk_fails;

  assign chk_fails = mem_subsystem_top_i.memory_arbiter_i.mem_arb_chk_i.fail_count;

  mem_subsystem_top mem_subsystem_top_i (.*);

  initial begin
    forever #5 CLK = ~CLK;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    assert (act === exp)
      else stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
  endtask

  function automatic int pick(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  task automatic next_cycle(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  task automatic data_access(input int w, input logic write, input word_t wdata,
                             output word_t rdata);
    d_cmd = '{addr: addr_t'(w * 4), wdata: wdata, write: write};
    d_req = 1'b1;
    do next_cycle(1); while (!d_ack);
    rdata = d_rdata;
    d_req = 1'b0;
    do next_cycle(1); while (d_ack);
  endtask

  task automatic fetch_word(input int w, output word_t rdata);
    i_addr = addr_t'(w * 4);
    i_req = 1'b1;
    do next_cycle(1); while (!i_ack);
    rdata = i_rdata;
    i_req = 1'b0;
    do next_cycle(1); while (i_ack);
  endtask

  task automatic scratch_load(input int base_w);
    int    rows;
    addr_t lo;
    rows = 0;
    sl_addr = addr_t'(base_w * 4);
    sl_req = 1'b1;
    do begin
      next_cycle(1);
      if (sl_row_valid) begin
        check_word("sl_row_idx", word_t'(rows), word_t'(sl_row.idx));
        lo = sl_addr + addr_t'(rows * ROW_STRIDE);
        check_word("sl_row_lo", model[lo / 4], sl_row.data[31:0]);
        check_word("sl_row_hi", model[(lo + WORD_BYTES) / 4], sl_row.data[63:32]);
        rows++;
      end
    end while (!sl_ack);
    check_word("sl_row_count", word_t'(SP_ROWS), word_t'(rows));
    sl_req = 1'b0;
    do next_cycle(1); while (sl_ack);
  endtask

  task automatic scratch_store(input int w, input dword_t data);
    ss_addr = addr_t'(w * 4);
    ss_data = data;
    ss_req = 1'b1;
    do next_cycle(1); while (!ss_ack);
    ss_req = 1'b0;
    do next_cycle(1); while (ss_ack);
    // low half at the base, high half one word up
    model[w] = data[31:0];
    model[w + 1] = data[63:32];
  endtask

  // in parallel data owns words 0..15, stores own 16..31 and fetch reads 32..63
  task automatic data_traffic();
    word_t rd;
    int    w;
    for (int n = 0; n < N_OPS; n++) begin
      next_cycle(pick(6));
      w = pick(16);
      if (pick(2) == 1) begin
        model[w] = $random(seed);
        data_access(w, 1'b1, model[w], rd);
      end else begin
        data_access(w, 1'b0, '0, rd);
        check_word("data_read", model[w], rd);
      end
    end
  endtask

  task automatic fetch_traffic();
    word_t rd;
    int    w;
    for (int n = 0; n < N_OPS; n++) begin
      next_cycle(pick(6));
      w = 32 + pick(32);
      fetch_word(w, rd);
      check_word("fetch_read", model[w], rd);
    end
  endtask

  task automatic scratch_traffic();
    dword_t data;
    for (int n = 0; n < N_OPS; n++) begin
      next_cycle(pick(6));
      if (pick(2) == 1) begin
        // rows span eight words, so base stays at or below word 56
        scratch_load(16 + pick(41));
      end else begin
        data = {$random(seed), $random(seed)};
        scratch_store(16 + pick(15), data);
      end
    end
  endtask

  always @(posedge CLK) begin
    since_reset <= nRST ? since_reset + 1 : 0;
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
      stop_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
  end

  always @(negedge CLK) begin
    if (!nRST || since_reset < 2) begin
      assert (!{i_ack, d_ack, sl_ack, ss_ack, sl_row_valid, mem_subsystem_top_i.ram_strb})
        else stop_run("an ack, row valid or RAM strobe is active in or right after reset");
    end
    // an ack may only rise while its req was already up
    assert (({i_ack, d_ack, sl_ack, ss_ack} & ~ack_q & ~req_q) == 4'b0)
      else stop_run("an ack rose without its req");
    assert (chk_fails == 0)
      else stop_run("an arbiter handshake assertion failed");
    ack_q = {i_ack, d_ack, sl_ack, ss_ack};
    req_q = {i_req, d_req, sl_req, ss_req};
  end

  initial begin
    word_t rd;
    i_req   = 1'b0;
    i_addr  = '0;
    d_req   = 1'b0;
    d_cmd   = '0;
    sl_req  = 1'b0;
    sl_addr = '0;
    ss_req  = 1'b0;
    ss_addr = '0;
    ss_data = '0;
    nRST    = 1'b0;
    repeat (2) @(posedge CLK);
    #1;
    nRST = 1'b1;
    next_cycle(2);
    // fill the region with known data
    for (int w = 0; w < REGION_WORDS; w++) begin
      model[w] = $random(seed);
      data_access(w, 1'b1, model[w], rd);
    end
    fork
      data_traffic();
      fetch_traffic();
      scratch_traffic();
    join
    // read everything back, scratchpad stores included
    for (int w = 0; w < REGION_WORDS; w++) begin
      data_access(w, 1'b0, '0, rd);
      check_word("readback", model[w], rd);
    end
    if (chk_fails == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_run("arbiter checker reported a failure");
    end
  end

endmodule

//--- sources.f
verilog/mem_arb_pkg.sv
verilog/scratch_burst.sv
verilog/memory_arbiter.sv
verilog/ram_model.sv
verilog/mem_subsystem_top.sv
sim/mem_arb_chk.sv
sim/tb_mem_subsystem.sv

//--- verilog/mem_arb_pkg.sv
package mem_arb_pkg;

  // scratchpad burst geometry
  localparam int SP_ROWS    = 4;
  localparam int ROW_STRIDE = 8;
  localparam int WORD_BYTES = 4;

  // ram timing and depth
  localparam int RAM_LATENCY = 3;
  localparam int RAM_WORDS   = 1024;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [63:0] dword_t;
  typedef logic [1:0]  row_idx_t;

  // one word access
  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  write;
  } mem_req_t;

  // one delivered scratchpad row
  typedef struct packed {
    row_idx_t idx;
    dword_t   data;
  } sp_row_t;

endpackage

//--- verilog/mem_subsystem_top.sv
module mem_subsystem_top import mem_arb_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     i_req,
  input  addr_t    i_addr,
  output logic     i_ack,
  output word_t    i_rdata,
  input  logic     d_req,
  input  mem_req_t d_cmd,
  output logic     d_ack,
  output word_t    d_rdata,
  input  logic     sl_req,
  input  addr_t    sl_addr,
  output logic     sl_ack,
  output logic     sl_row_valid,
  output sp_row_t  sl_row,
  input  logic     ss_req,
  input  addr_t    ss_addr,
  input  dword_t   ss_data,
  output logic     ss_ack
);

  // sequencer to arbiter
  logic     sp_req;
  logic     sp_ack;
  mem_req_t sp_cmd;
  word_t    sp_rdata;

  // arbiter to ram
  logic     ram_strb;
  logic     ram_done;
  mem_req_t ram_cmd;
  word_t    ram_rdata;

  scratch_burst scratch_burst_i (
    .CLK, .nRST,
    .sl_req, .sl_addr, .sl_ack, .sl_row_valid, .sl_row,
    .ss_req, .ss_addr, .ss_data, .ss_ack,
    .sp_req, .sp_cmd, .sp_ack, .sp_rdata
  );

  memory_arbiter memory_arbiter_i (
    .CLK, .nRST,
    .sp_req, .sp_cmd, .sp_ack, .sp_rdata,
    .d_req, .d_cmd, .d_ack, .d_rdata,
    .i_req, .i_addr, .i_ack, .i_rdata,
    .ram_strb, .ram_cmd, .ram_done, .ram_rdata
  );

  ram_model ram_model_i (
    .CLK, .nRST,
    .ram_strb, .ram_cmd,
    .ram_done, .ram_rdata
  );

endmodule

//--- verilog/memory_arbiter.sv
module memory_arbiter import mem_arb_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     sp_req,
  input  mem_req_t sp_cmd,
  output logic     sp_ack,
  output word_t    sp_rdata,
  input  logic     d_req,
  input  mem_req_t d_cmd,
  output logic     d_ack,
  output word_t    d_rdata,
  input  logic     i_req,
  input  addr_t    i_addr,
  output logic     i_ack,
  output word_t    i_rdata,
  output logic     ram_strb,
  output mem_req_t ram_cmd,
  input  logic     ram_done,
  input  word_t    ram_rdata
);

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT, ACK} state_t;
  typedef enum logic [1:0] {OWN_SP, OWN_D, OWN_I} owner_t;

  state_t   state, next_state;
  owner_t   grant, next_grant;
  mem_req_t cmd_q;
  mem_req_t i_cmd;
  word_t    rdata_q;
  logic     owner_req;

  assign i_cmd.addr  = i_addr;
  assign i_cmd.wdata = '0;
  assign i_cmd.write = 1'b0;

  always_comb begin
    case (grant)
      OWN_SP:  owner_req = sp_req;
      OWN_D:   owner_req = d_req;
      default: owner_req = i_req;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      grant <= OWN_I;
    end else begin
      state <= next_state;
      grant <= next_grant;
    end
  end

  always_comb begin
    next_state = state;
    next_grant = grant;
    case (state)
      IDLE: begin
        // fixed priority: scratchpad, data, instruction
        if (sp_req) begin
          next_grant = OWN_SP;
          next_state = ISSUE;
        end else if (d_req) begin
          next_grant = OWN_D;
          next_state = ISSUE;
        end else if (i_req) begin
          next_grant = OWN_I;
          next_state = ISSUE;
        end
      end
      ISSUE: next_state = WAIT;
      WAIT: begin
        if (ram_done) next_state = ACK;
      end
      ACK: begin
        // owner keeps the bus until it lets go of req
        if (!owner_req) next_state = IDLE;
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (state == IDLE) begin
      if (sp_req) cmd_q <= sp_cmd;
      else if (d_req) cmd_q <= d_cmd;
      else cmd_q <= i_cmd;
    end
    if (state == WAIT && ram_done) rdata_q <= ram_rdata;
  end

  assign ram_strb = (state == ISSUE);
  assign ram_cmd  = cmd_q;

  assign sp_ack = (state == ACK) && (grant == OWN_SP);
  assign d_ack  = (state == ACK) && (grant == OWN_D);
  assign i_ack  = (state == ACK) && (grant == OWN_I);

  // read data only meaningful while the matching ack is high
  assign sp_rdata = rdata_q;
  assign d_rdata  = rdata_q;
  assign i_rdata  = rdata_q;

endmodule

//--- verilog/ram_model.sv
module ram_model import mem_arb_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     ram_strb,
  input  mem_req_t ram_cmd,
  output logic     ram_done,
  output word_t    ram_rdata
);

  word_t                          mem [RAM_WORDS];
  logic [RAM_LATENCY-1:0]         lat_sr;
  mem_req_t                       cmd_q;
  logic [$clog2(RAM_WORDS)-1:0]   widx;

  // strobe travels through the delay line to done
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_sr <= '0;
    end else begin
      lat_sr <= {lat_sr[RAM_LATENCY-2:0], ram_strb};
    end
  end

  always_ff @(posedge CLK) begin
    if (ram_strb) cmd_q <= ram_cmd;
  end

  // word index from byte address
  assign widx = cmd_q.addr[$clog2(RAM_WORDS)+1:2];

  always_ff @(posedge CLK) begin
    if (ram_done && cmd_q.write) mem[widx] <= cmd_q.wdata;
  end

  assign ram_done  = lat_sr[RAM_LATENCY-1];
  assign ram_rdata = mem[widx];

endmodule

//--- verilog/scratch_burst.sv
module scratch_burst import mem_arb_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     sl_req,
  input  addr_t    sl_addr,
  output logic     sl_ack,
  output logic     sl_row_valid,
  output sp_row_t  sl_row,
  input  logic     ss_req,
  input  addr_t    ss_addr,
  input  dword_t   ss_data,
  output logic     ss_ack,
  output logic     sp_req,
  output mem_req_t sp_cmd,
  input  logic     sp_ack,
  input  word_t    sp_rdata
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_DROP, S_ACK} state_t;

  state_t   state, next_state;
  logic     is_load, next_is_load;
  row_idx_t row_q, next_row;
  logic     half_q, next_half;
  logic     valid_q;
  logic     last_row;
  addr_t    base_q;
  dword_t   data_q;
  sp_row_t  row_out;

  // store covers only row 0
  assign last_row = !is_load || (row_q == row_idx_t'(SP_ROWS - 1));

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= S_IDLE;
      is_load <= 1'b0;
      row_q   <= '0;
      half_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      state   <= next_state;
      is_load <= next_is_load;
      row_q   <= next_row;
      half_q  <= next_half;
      // high half of a load row just arrived
      valid_q <= (state == S_REQ) && sp_ack && half_q && is_load;
    end
  end

  always_comb begin
    next_state   = state;
    next_is_load = is_load;
    next_row     = row_q;
    next_half    = half_q;
    case (state)
      S_IDLE: begin
        next_row  = '0;
        next_half = 1'b0;
        if (sl_req) begin
          next_is_load = 1'b1;
          next_state   = S_REQ;
        end else if (ss_req) begin
          next_is_load = 1'b0;
          next_state   = S_REQ;
        end
      end
      S_REQ: begin
        if (sp_ack) next_state = S_DROP;
      end
      S_DROP: begin
        // wait for the arbiter to release before the next word
        if (!sp_ack) begin
          if (!half_q) begin
            next_half  = 1'b1;
            next_state = S_REQ;
          end else if (!last_row) begin
            next_half  = 1'b0;
            next_row   = row_q + 1'b1;
            next_state = S_REQ;
          end else begin
            next_state = S_ACK;
          end
        end
      end
      S_ACK: begin
        if (!(is_load ? sl_req : ss_req)) next_state = S_IDLE;
      end
      default: next_state = S_IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (state == S_IDLE) begin
      base_q <= sl_req ? sl_addr : ss_addr;
      data_q <= ss_data;
    end
    if (state == S_REQ && sp_ack && is_load) begin
      if (half_q) begin
        row_out.data[63:32] <= sp_rdata;
        row_out.idx         <= row_q;
      end else begin
        row_out.data[31:0] <= sp_rdata;
      end
    end
  end

  assign sp_req        = (state == S_REQ);
  assign sp_cmd.addr   = base_q + addr_t'(row_q) * ROW_STRIDE + (half_q ? WORD_BYTES : 0);
  assign sp_cmd.wdata  = half_q ? data_q[63:32] : data_q[31:0];
  assign sp_cmd.write  = !is_load;

  assign sl_row_valid = valid_q;
  assign sl_row       = row_out;
  assign sl_ack       = (state == S_ACK) && is_load;
  assign ss_ack       = (state == S_ACK) && !is_load;

endmodule
